/* list.f */
logic/n64_vid_pkg.sv
logic/n64_vinfo_ext.sv
logic/n64_vdemux.sv
logic/n64_vid_regs.sv
logic/n64_vid_in_top.sv
tb/n64_vid_checker.sv
tb/tb_n64_vid_in.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then judge the log
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -f list.f \
  --top-module tb_n64_vid_in -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "Test failures found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

/* tb/tb_n64_vid_in.sv */
// Testbench top for the N64 video input stage.
// Drives pixel groups and whole frames onto the video bus and runs APB
// accesses, all on the falling edge of VCLK. The checker instance does
// the comparing; this module sequences the tests and reports per test.

`timescale 1ns/1ps
`default_nettype none

module tb_n64_vid_in;

  import n64_vid_pkg::*;

  localparam int RST_CYCLES   = 8;
  localparam int GRP_PER_LINE = 2;
  localparam int VS_LINES     = 2;    // lines with nVSYNC low
  localparam int TOTAL_LINES  = 49;   // all frames of all tests
  localparam int APB_OPS      = 23;
  localparam int APB_CYCLES   = 3;    // setup, access, idle
  localparam int TIMEOUT_CYCLES =
    2 * (RST_CYCLES + TOTAL_LINES * GRP_PER_LINE * 4 + APB_OPS * APB_CYCLES);

  logic      VCLK;
  logic      nRST;
  logic      nDSYNC;
  color_t    D;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;
  logic      pix_valid;
  rgb_t      pix_rgb;
  sync_t     pix_sync;
  vinfo_t    vinfo;

  int   err_cnt;
  int   chk_cnt;
  int   cycle_cnt    = 0;
  int   err_base     = 0;
  int   tests_run    = 0;
  int   tests_failed = 0;
  int   prev_lines   = 0;
  int   last_lines   = 0;
  logic prev_odd     = 1'b0;   // parity history starts even after reset
  logic last_odd     = 1'b0;

  n64_vid_in_top i_dut (
    .VCLK(VCLK), .nRST(nRST), .nDSYNC(nDSYNC), .D(D),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .pix_valid(pix_valid), .pix_rgb(pix_rgb), .pix_sync(pix_sync), .vinfo(vinfo)
  );

  n64_vid_checker i_chk (
    .VCLK(VCLK), .nRST(nRST), .nDSYNC(nDSYNC), .D(D),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .pix_valid(pix_valid), .pix_rgb(pix_rgb), .pix_sync(pix_sync), .vinfo(vinfo),
    .frm_lines(prev_lines), .frm_odd(last_odd), .frm_odd_pre(prev_odd),
    .err_cnt(err_cnt), .chk_cnt(chk_cnt)
  );

  initial begin
    VCLK = 1'b0;
    forever #5 VCLK = ~VCLK;
  end

  always @(posedge VCLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  // ====================================================================
  // stimulus tasks
  // ====================================================================

  task automatic send_group(input sync_t s);
    @(negedge VCLK);
    nDSYNC = 1'b0;
    D      = {3'($urandom), s};           // upper bits unused in the sync slot
    repeat (3) begin
      @(negedge VCLK);
      nDSYNC = 1'b1;
      D      = color_t'($urandom);        // red, green, blue
    end
  endtask

  // odd frames drop nVSYNC together with nHSYNC, even ones a group later
  task automatic send_frame(input int lines, input logic odd);
    int   l;
    int   g;
    logic vs_n;
    logic hs_n;
    for (l = 0; l < lines; l++) begin
      for (g = 0; g < GRP_PER_LINE; g++) begin
        hs_n = (g != 0);                  // hsync low in the first group
        vs_n = !(l < VS_LINES && (odd || l != 0 || g != 0));
        send_group({vs_n, 1'b1, hs_n, vs_n & hs_n});
      end
    end
    prev_lines = last_lines;
    last_lines = lines;
    prev_odd   = last_odd;
    last_odd   = odd;
  endtask

  task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t data);
    @(negedge VCLK);
    psel    = 1'b1;                       // setup
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(negedge VCLK);
    penable = 1'b1;                       // access cycle without wait states
    @(negedge VCLK);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic end_test(input string name);
    int errs;
    errs      = err_cnt - err_base;
    err_base  = err_cnt;
    tests_run = tests_run + 1;
    if (errs != 0)
      tests_failed = tests_failed + 1;
    $display("test %0d %s: %s, %0d errors", tests_run, name, errs == 0 ? "ok" : "FAILED", errs);
  endtask

  // ====================================================================
  // test sequence
  // ====================================================================

  initial begin
    void'($urandom(32'h9a1e9a25));
    nRST    = 1'b0;
    nDSYNC  = 1'b1;
    D       = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (RST_CYCLES) @(posedge VCLK);
    @(negedge VCLK);
    nRST = 1'b1;

    apb_access(1'b0, REG_CTRL, '0);
    apb_access(1'b0, REG_PIX_CNT, '0);
    apb_access(1'b0, REG_LAST_PIX, '0);
    end_test("reset values");

    apb_access(1'b1, REG_CTRL, 32'h1);    // capture on
    send_frame(5, 1'b1);
    send_frame(5, 1'b1);
    repeat (3) @(negedge VCLK);           // let the last pixel come out
    end_test("demux");

    apb_access(1'b0, REG_STATUS, '0);     // 5 lines read as PAL
    send_frame(7, 1'b1);
    send_frame(7, 1'b1);
    apb_access(1'b0, REG_STATUS, '0);     // 7 lines read as NTSC
    end_test("mode detection");

    send_frame(5, 1'b0);
    send_frame(5, 1'b0);
    apb_access(1'b0, REG_STATUS, '0);     // same alignment reads as progressive
    send_frame(5, 1'b1);
    send_frame(5, 1'b0);
    apb_access(1'b0, REG_STATUS, '0);     // alternating parity reads as interlaced
    end_test("interlace");

    apb_access(1'b0, REG_PIX_CNT, '0);
    apb_access(1'b0, REG_LAST_PIX, '0);
    apb_access(1'b1, REG_CTRL, '0);       // capture off
    apb_access(1'b0, REG_CTRL, '0);
    send_frame(5, 1'b0);
    apb_access(1'b0, REG_PIX_CNT, '0);    // both hold their values
    apb_access(1'b0, REG_LAST_PIX, '0);
    apb_access(1'b1, REG_PIX_CNT, 32'hffff_ffff);
    apb_access(1'b0, REG_PIX_CNT, '0);
    end_test("capture registers");

    apb_access(1'b1, REG_STATUS, 32'h3);
    apb_access(1'b1, REG_LAST_PIX, 32'h1);
    apb_access(1'b0, 4'h2, '0);
    apb_access(1'b1, 4'h6, 32'h1);
    apb_access(1'b0, 4'hF, '0);
    apb_access(1'b1, REG_CTRL, 32'h1);
    apb_access(1'b0, REG_CTRL, '0);
    end_test("apb errors");

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, chk_cnt, err_cnt);
    if (tests_failed == 0 && err_cnt == 0 && chk_cnt > 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/n64_vid_checker.sv */
// Checker for the N64 video input stage.
// Rebuilds each pixel group from the video bus and predicts the APB
// register contents, then compares every pix_valid pulse and every APB
// access against that model. Errors and checks are counted for the
// testbench top, which reports them.

`timescale 1ns/1ps
`default_nettype none

module n64_vid_checker (
  input  logic                   VCLK,
  input  logic                   nRST,
  input  logic                   nDSYNC,
  input  n64_vid_pkg::color_t    D,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  n64_vid_pkg::apb_addr_t paddr,
  input  n64_vid_pkg::apb_data_t pwdata,
  input  n64_vid_pkg::apb_data_t prdata,
  input  logic                   pready,
  input  logic                   pslverr,
  input  logic                   pix_valid,
  input  n64_vid_pkg::rgb_t      pix_rgb,
  input  n64_vid_pkg::sync_t     pix_sync,
  input  n64_vid_pkg::vinfo_t    vinfo,
  input  int                     frm_lines,     // lines of the frame before the last
  input  logic                   frm_odd,       // parity of the last frame
  input  logic                   frm_odd_pre,   // parity of the frame before it
  output int                     err_cnt,
  output int                     chk_cnt
);

  import n64_vid_pkg::*;

  sync_t       sync_q;     // sync word of the group on the bus
  color_t      red_q;
  color_t      grn_q;
  data_phase_t ph;         // bus phase the next cycle should carry
  logic        grp_busy;   // colors of a group still pending
  logic        vld_exp;    // a pixel is due in this cycle
  rgb_t        rgb_exp;
  sync_t       sync_exp;
  logic        cap_exp;    // model of capture_en
  apb_data_t   cnt_exp;
  rgb_t        last_exp;

  // ====================================================================
  // reference functions
  // ====================================================================

  function automatic rgb_t exp_pixel(input color_t r, input color_t g, input color_t b);
    return {r, g, b};                       // red on top
  endfunction

  function automatic logic exp_vmode(input int lines);
    return (lines % 4) <= 1;                // 0 or 1 modulo 4 means PAL
  endfunction

  function automatic logic exp_480i(input logic pre_odd, input logic cur_odd);
    return pre_odd != cur_odd;              // parity toggles in interlaced video
  endfunction

  function automatic logic bad_access(input apb_addr_t addr, input logic wr);
    case (addr)
      REG_CTRL, REG_PIX_CNT:    return 1'b0;
      REG_STATUS, REG_LAST_PIX: return wr;  // read only
      default:                  return 1'b1;
    endcase
  endfunction

  function automatic apb_data_t exp_rdata(input apb_addr_t addr);
    case (addr)
      REG_CTRL:    return apb_data_t'(cap_exp);
      REG_STATUS:  return {30'b0, exp_vmode(frm_lines), exp_480i(frm_odd_pre, frm_odd)};
      REG_PIX_CNT: return cnt_exp;
      default:     return apb_data_t'(last_exp);
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    chk_cnt = chk_cnt + 1;
    if (act !== exp) begin
      err_cnt = err_cnt + 1;
      $display("CHECK FAILED %s expected 0x%h got 0x%h at %0t", name, exp, act, $time);
    end
  endtask

  wire access  = psel && penable;
  wire err_exp = access && bad_access(paddr, pwrite);

  // ====================================================================
  // model and compare
  // ====================================================================

  always @(posedge VCLK) begin
    if (!nRST) begin
      sync_q   <= SYNC_IDLE;
      ph       <= '0;
      grp_busy <= 1'b0;
      vld_exp  <= 1'b0;
      cap_exp  <= 1'b0;
      cnt_exp  <= '0;
      last_exp <= '0;
    end else begin
      check_value("pix_valid", 32'(vld_exp), 32'(pix_valid));
      if (vld_exp) begin
        check_value("pix_rgb", 32'(rgb_exp), 32'(pix_rgb));
        check_value("pix_sync", 32'(sync_exp), 32'(pix_sync));
      end
      if (nDSYNC && grp_busy)               // phase counter during colors
        check_value("vinfo.data_cnt", 32'(ph), 32'(vinfo[VINFO_W-1 -: PHASE_W]));
      vld_exp <= nDSYNC && grp_busy && ph == PH_BLUE;
      if (!nDSYNC) begin
        sync_q   <= D[SYNC_W-1:0];
        ph       <= PH_RED;
        grp_busy <= 1'b1;
      end else if (grp_busy) begin
        ph <= ph + 2'd1;
        case (ph)
          PH_RED:   red_q <= D;
          PH_GREEN: grn_q <= D;
          default: begin                    // blue closes the group
            rgb_exp  <= exp_pixel(red_q, grn_q, D);
            sync_exp <= sync_q;
            grp_busy <= 1'b0;
          end
        endcase
      end
      // apb side
      check_value("pslverr", 32'(err_exp), 32'(pslverr));
      if (access) begin
        check_value("pready", 32'd1, 32'(pready));
        if (!pwrite && !err_exp)
          check_value("prdata", exp_rdata(paddr), prdata);
      end
      if (vld_exp && cap_exp) begin
        cnt_exp  <= cnt_exp + 32'd1;
        last_exp <= rgb_exp;
      end
      if (access && pwrite && !err_exp) begin
        if (paddr == REG_CTRL)
          cap_exp <= pwdata[0];
        if (paddr == REG_PIX_CNT)
          cnt_exp <= '0;                    // clear wins over a capture
      end
    end
  end

endmodule

`default_nettype wire

/* logic/n64_vid_in_top.sv */
// Top level of the N64 video input stage.
// The demux splits the bus into pixels, the info extractor runs the data
// phase and mode detection, and the register block exposes status and
// capture over APB. Everything runs on VCLK.

`timescale 1ns/1ps
`default_nettype none

module n64_vid_in_top (
  input  logic                   VCLK,
  input  logic                   nRST,
  input  logic                   nDSYNC,
  input  n64_vid_pkg::color_t    D,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  n64_vid_pkg::apb_addr_t paddr,
  input  n64_vid_pkg::apb_data_t pwdata,
  output n64_vid_pkg::apb_data_t prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic                   pix_valid,
  output n64_vid_pkg::rgb_t      pix_rgb,
  output n64_vid_pkg::sync_t     pix_sync,
  output n64_vid_pkg::vinfo_t    vinfo
);

  import n64_vid_pkg::*;

  sync_t sync_pre;   // sync word one period back
  sync_t sync_cur;   // newest sync word

  n64_vdemux i_vdemux (
    .VCLK      (VCLK),
    .nRST      (nRST),
    .nDSYNC    (nDSYNC),
    .D         (D),
    .data_cnt  (vinfo[VINFO_W-1 -: PHASE_W]),  // data_cnt is the top field
    .sync_pre  (sync_pre),
    .sync_cur  (sync_cur),
    .pix_valid (pix_valid),
    .pix_rgb   (pix_rgb),
    .pix_sync  (pix_sync)
  );

  n64_vinfo_ext i_vinfo_ext (
    .VCLK     (VCLK),
    .nRST     (nRST),
    .nVDSYNC  (nDSYNC),
    .sync_pre (sync_pre),
    .sync_cur (sync_cur),
    .vinfo    (vinfo)
  );

  n64_vid_regs i_vid_regs (
    .VCLK      (VCLK),
    .nRST      (nRST),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .vinfo     (vinfo),
    .pix_valid (pix_valid),
    .pix_rgb   (pix_rgb)
  );

endmodule

`default_nettype wire

/* logic/n64_vid_regs.sv */
// APB register block for the video input stage.
// CTRL holds capture_en, STATUS reports vmode and 480i, PIX_CNT counts
// pixels captured while capture_en is set and LAST_PIX holds the newest of
// them. No wait states; pslverr flags unknown offsets and writes to
// read-only registers in the access cycle.

`timescale 1ns/1ps
`default_nettype none

module n64_vid_regs (
  input  logic                   VCLK,
  input  logic                   nRST,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  n64_vid_pkg::apb_addr_t paddr,
  input  n64_vid_pkg::apb_data_t pwdata,
  output n64_vid_pkg::apb_data_t prdata,
  output logic                   pready,
  output logic                   pslverr,
  input  n64_vid_pkg::vinfo_t    vinfo,
  input  logic                   pix_valid,
  input  n64_vid_pkg::rgb_t      pix_rgb
);

  import n64_vid_pkg::*;

  logic      capture_en;
  apb_data_t pix_cnt;
  rgb_t      last_pix;
  apb_data_t rdata;
  logic      addr_bad;   // offset outside the map
  logic      read_only;

  wire access  = psel && penable;
  wire wr_en   = access && pwrite && !pslverr;
  wire capture = pix_valid && capture_en;

  // ====================================================================
  // address decode and read mux
  // ====================================================================

  always_comb begin
    rdata     = '0;
    addr_bad  = 1'b0;
    read_only = 1'b0;
    case (paddr)
      REG_CTRL:     rdata[0] = capture_en;
      REG_STATUS: begin
        rdata[1]  = vinfo[VINFO_VMODE];
        rdata[0]  = vinfo[VINFO_480I];
        read_only = 1'b1;
      end
      REG_PIX_CNT:  rdata = pix_cnt;
      REG_LAST_PIX: begin
        rdata[RGB_W-1:0] = last_pix;
        read_only        = 1'b1;
      end
      default:      addr_bad = 1'b1;
    endcase
  end

  assign pready  = 1'b1;                    // never stalls
  assign pslverr = access && (addr_bad || (pwrite && read_only));
  assign prdata  = access ? rdata : '0;

  // ====================================================================
  // register updates
  // ====================================================================

  always_ff @(posedge VCLK) begin
    if (!nRST) begin
      capture_en <= 1'b0;
      pix_cnt    <= '0;
      last_pix   <= '0;
    end else begin
      if (wr_en && paddr == REG_CTRL)
        capture_en <= pwdata[0];
      if (wr_en && paddr == REG_PIX_CNT)
        pix_cnt <= '0;                      // clear beats a same-cycle capture
      else if (capture)
        pix_cnt <= pix_cnt + 32'd1;
      if (capture)
        last_pix <= pix_rgb;
    end
  end

endmodule

`default_nettype wire

/* logic/n64_vdemux.sv */
// Demultiplexer for the N64 digital video bus.
// Captures the sync word in every nDSYNC-low cycle and keeps the previous
// one for the info extractor. The three color words that follow are held
// and presented as one pixel with its sync word, flagged by a one-cycle
// pix_valid in the cycle right after the blue phase.

`timescale 1ns/1ps
`default_nettype none

module n64_vdemux (
  input  logic                     VCLK,
  input  logic                     nRST,
  input  logic                     nDSYNC,
  input  n64_vid_pkg::color_t      D,
  input  n64_vid_pkg::data_phase_t data_cnt,
  output n64_vid_pkg::sync_t       sync_pre,
  output n64_vid_pkg::sync_t       sync_cur,
  output logic                     pix_valid,
  output n64_vid_pkg::rgb_t        pix_rgb,
  output n64_vid_pkg::sync_t       pix_sync
);

  import n64_vid_pkg::*;

  color_t red_q;
  color_t green_q;
  logic   grp_open;    // a sync word was seen, colors of its group pending

  // ====================================================================
  // control path: sync history and valid pulse
  // ====================================================================

  always_ff @(posedge VCLK) begin
    if (!nRST) begin
      sync_pre  <= SYNC_IDLE;
      sync_cur  <= SYNC_IDLE;
      grp_open  <= 1'b0;
      pix_valid <= 1'b0;
    end else begin
      pix_valid <= 1'b0;                    // single cycle pulse
      if (!nDSYNC) begin
        sync_pre <= sync_cur;               // shift history
        sync_cur <= D[SYNC_W-1:0];
        grp_open <= 1'b1;
      end else if (grp_open && data_cnt == PH_BLUE) begin
        grp_open  <= 1'b0;                  // group complete
        pix_valid <= 1'b1;
      end
    end
  end

  // ====================================================================
  // payload path: color holding and pixel assembly
  // ====================================================================

  // red and green wait here until blue completes the group
  always_ff @(posedge VCLK) begin
    if (!nRST) begin
      red_q    <= '0;
      green_q  <= '0;
      pix_rgb  <= '0;
      pix_sync <= SYNC_IDLE;                // inactive until the first group
    end else if (nDSYNC && grp_open) begin
      case (data_cnt)
        PH_RED:   red_q   <= D;
        PH_GREEN: green_q <= D;
        PH_BLUE: begin
          pix_rgb  <= {red_q, green_q, D};  // blue taken straight off the bus
          pix_sync <= sync_cur;             // sync word of this group
        end
        default: ;                          // phase 0 is the sync slot
      endcase
    end
  end

  // the output registers only change in the blue phase, so the pixel on
  // pix_rgb stays stable while the next group is being captured

endmodule

`default_nettype wire

/* logic/n64_vinfo_ext.sv */
// Video info extractor for the N64 digital video bus.
// Runs the data phase counter used by the demux and derives PAL/NTSC and
// 240p/480i from edges between two consecutive sync words. Edges are only
// looked at in sync cycles, so the pair seen is one sync period old.

`timescale 1ns/1ps
`default_nettype none

module n64_vinfo_ext (
  input  logic                VCLK,
  input  logic                nRST,
  input  logic                nVDSYNC,
  input  n64_vid_pkg::sync_t  sync_pre,
  input  n64_vid_pkg::sync_t  sync_cur,
  output n64_vid_pkg::vinfo_t vinfo
);

  import n64_vid_pkg::*;

  data_phase_t data_cnt;
  logic        frame_id;   // 0 even frame, 1 odd frame
  logic        n64_480i;   // 1 when parity toggles frame to frame
  logic [1:0]  line_cnt;   // only the low bits matter for the mode guess
  logic        vmode;      // 1 PAL, 0 NTSC

  // edge detection between the two sync words
  wire vsync_rise = !sync_pre[SYNC_NVSYNC] &&  sync_cur[SYNC_NVSYNC];
  wire vsync_fall =  sync_pre[SYNC_NVSYNC] && !sync_cur[SYNC_NVSYNC];
  wire hsync_rise = !sync_pre[SYNC_NHSYNC] &&  sync_cur[SYNC_NHSYNC];
  wire hsync_fall =  sync_pre[SYNC_NHSYNC] && !sync_cur[SYNC_NHSYNC];

  // ====================================================================
  // data phase counter
  // ====================================================================

  always_ff @(posedge VCLK) begin
    if (!nRST) begin
      data_cnt <= '0;
    end else if (!nVDSYNC) begin
      data_cnt <= PH_RED;                   // red follows the sync cycle
    end else begin
      data_cnt <= data_cnt + 2'd1;          // green, blue, then wraps
    end
  end

  // ====================================================================
  // interlace detection
  // ====================================================================

  always_ff @(posedge VCLK) begin
    if (!nRST) begin
      frame_id <= 1'b0;
      n64_480i <= 1'b0;
    end else if (!nVDSYNC && vsync_fall) begin
      if (hsync_fall) begin                 // hsync falls with vsync on an odd frame
        n64_480i <= ~frame_id;
        frame_id <= 1'b1;
      end else begin                        // even frame
        n64_480i <= frame_id;
        frame_id <= 1'b0;
      end
    end
  end

  // ====================================================================
  // PAL / NTSC from line count modulo 4
  // ====================================================================

  always_ff @(posedge VCLK) begin
    if (!nRST) begin
      line_cnt <= '0;
      vmode    <= 1'b0;
    end else if (!nVDSYNC) begin
      if (vsync_rise) begin
        line_cnt <= '0;                     // new frame
        vmode    <= ~line_cnt[1];           // 0x -> PAL, 1x -> NTSC
      end else if (hsync_rise) begin
        line_cnt <= line_cnt + 2'd1;
      end
    end
  end

  assign vinfo = {data_cnt, vmode, n64_480i};

endmodule

`default_nettype wire

/* logic/n64_vid_pkg.sv */
// Shared types and constants for the N64 video input stage.
// Holds the bus widths, the vector types that travel between the demux,
// the video info extractor and the APB register block, plus the register map.
// Modules import it with a wildcard inside their body.

`default_nettype none

package n64_vid_pkg;

  // bus and field widths
  localparam int COLOR_W    = 7;            // one color word on D
  localparam int SYNC_W     = 4;            // nVSYNC,nCLAMP,nHSYNC,nCSYNC
  localparam int PHASE_W    = 2;
  localparam int VINFO_W    = 4;            // data_cnt,vmode,n64_480i
  localparam int RGB_W      = 3 * COLOR_W;
  localparam int APB_ADDR_W = 4;
  localparam int APB_DATA_W = 32;

  typedef logic [COLOR_W-1:0]    color_t;
  typedef logic [SYNC_W-1:0]     sync_t;
  typedef logic [VINFO_W-1:0]    vinfo_t;
  typedef logic [PHASE_W-1:0]    data_phase_t;
  typedef logic [RGB_W-1:0]      rgb_t;     // {red, green, blue}
  typedef logic [APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [APB_DATA_W-1:0] apb_data_t;

  // sync word bit positions
  // nCLAMP (2) and nCSYNC (0) are only passed through
  localparam int SYNC_NVSYNC = 3;
  localparam int SYNC_NHSYNC = 1;
  localparam sync_t SYNC_IDLE = 4'hF;       // all syncs inactive

  // vinfo bit positions below data_cnt
  localparam int VINFO_VMODE = 1;           // 1 = PAL
  localparam int VINFO_480I  = 0;

  // data phase counter values
  localparam data_phase_t PH_RED   = 2'd1;
  localparam data_phase_t PH_GREEN = 2'd2;
  localparam data_phase_t PH_BLUE  = 2'd3;

  // APB register map
  localparam apb_addr_t REG_CTRL     = 4'h0; // capture_en in bit 0 is read/write
  localparam apb_addr_t REG_STATUS   = 4'h4; // read only vmode in bit 1 and n64_480i in bit 0
  localparam apb_addr_t REG_PIX_CNT  = 4'h8; // count of captured pixels that any write clears
  localparam apb_addr_t REG_LAST_PIX = 4'hC; // read only copy of the last captured rgb_t

endpackage

`default_nettype wire
